//--- sim.f
+incdir+logic
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/mem_if.sv
logic/ifu.sv
logic/idu.sv
logic/exu.sv
logic/lsu.sv
logic/wbu.sv
logic/mem_arbiter.sv
logic/cpu_top.sv
tests/retire_checker.sv
tests/cpu_tb.sv

//--- tests/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import isa_pkg::*;
  import bus_pkg::*;

  localparam int PROG_LEN       = 200;
  localparam int MEM_WORDS      = 512;
  localparam int RETIRE_TIMEOUT = 2000;  // cycles allowed per instruction
  localparam int DRAIN_CYCLES   = 40;

  logic        clk;
  logic        rst_n;
  logic        mem_req_valid;
  logic        mem_req_ready;
  addr_t       mem_addr;
  logic        mem_wen;
  logic [31:0] mem_wdata;
  strb_t       mem_strb;
  logic        mem_rsp_valid;
  logic [31:0] mem_rdata;
  logic        retire_valid;
  word_t       retire_pc;
  reg_idx_t    retire_rd;
  word_t       retire_wd;
  logic        halted;

  int          err_count;
  int          retire_count;
  int          model_count;
  logic        model_halted;

  logic [31:0] mem [MEM_WORDS];  // words 0..255 program, 256..511 data
  logic [31:0] rand_state = 32'd79693;

  cpu_top dut_i (.*);

  retire_checker checker_i (.*, .image(mem));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  // one random instruction at word idx, control flow only jumps forward
  function automatic logic [31:0] gen_inst(int idx);
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] doff;
    logic [12:0] boff;
    logic [20:0] joff;
    int          span;
    int          kind;
    rd   = 5'(next_rand() % 16);
    rs1  = 5'(next_rand() % 16);
    rs2  = 5'(next_rand() % 16);
    f3   = 3'(next_rand());
    alt  = (next_rand() % 2 == 1);
    span = 1 + next_rand() % 8;
    if (idx + span > PROG_LEN - 1) span = PROG_LEN - 1 - idx;
    boff = 13'(span * 4);
    joff = 21'(span * 4);
    doff = 12'(32'h400 + 4 * (next_rand() % 32));  // small window so loads hit stores
    kind = next_rand() % 10;
    case (kind)
      0, 1, 2: begin
        alt = alt && (f3 == 3'd0 || f3 == 3'd5);  // sub, sra
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33};
      end
      3, 4: begin
        case (f3[1:0])
          2'd0: f3 = 3'd0;
          2'd1: f3 = 3'd4;
          2'd2: f3 = 3'd6;
          default: f3 = 3'd7;
        endcase
        return {12'(next_rand()), rs1, f3, rd, 7'h13};
      end
      5: return {20'(next_rand()), rd, 7'h37};
      6: return {doff, 5'd0, 3'b010, rd, 7'h03};
      7: return {doff[11:5], rs2, 5'd0, 3'b010, doff[4:0], 7'h23};
      8: return {boff[12], boff[10:5], rs2, rs1, 2'b00, alt, boff[4:1], boff[11], 7'h63};
      default: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
    endcase
  endfunction

  // memory model, random ready stall and response delay
  initial begin
    logic [8:0]  idx;
    logic        wr;
    logic [31:0] wd;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = '0;
    forever begin
      @(negedge clk);
      mem_rsp_valid = 1'b0;
      if (rst_n && mem_req_valid) begin
        repeat (next_rand() % 4) @(negedge clk);
        idx = mem_addr[10:2];
        wr  = mem_wen;
        wd  = mem_wdata;
        mem_req_ready = 1'b1;
        @(negedge clk);
        mem_req_ready = 1'b0;
        repeat (next_rand() % 4) @(negedge clk);  // 1 to 4 cycles after accept
        if (wr) mem[idx] = wd;
        mem_rdata     = mem[idx];
        mem_rsp_valid = 1'b1;
      end
    end
  end

  initial begin
    int   idle;
    int   cycles;
    logic timed_out;
    rst_n = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = next_rand();
    for (int i = 0; i < PROG_LEN - 1; i++) mem[i] = gen_inst(i);
    mem[PROG_LEN - 1] = 32'h0010_0073;  // ebreak
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    idle   = 0;
    cycles = 0;
    while (!halted && idle < RETIRE_TIMEOUT && cycles < PROG_LEN * RETIRE_TIMEOUT) begin
      @(negedge clk);
      idle = retire_valid ? 0 : idle + 1;
      cycles++;
    end
    timed_out = !halted;
    if (timed_out) begin
      $display("timeout: the core did not halt, %0d cycles since the last retire", idle);
    end else begin
      repeat (DRAIN_CYCLES) @(negedge clk);  // watch for requests after halt
    end
    if (retire_count != model_count) begin
      $display("retire count %0d does not match the model count %0d",
               retire_count, model_count);
    end

    $display("retired %0d, model %0d, errors %0d", retire_count, model_count, err_count);
    if (!timed_out && err_count == 0 && model_halted && retire_count == model_count) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/retire_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module retire_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_req_valid,
  input  logic              mem_req_ready,
  input  bus_pkg::addr_t    mem_addr,
  input  logic              mem_wen,
  input  logic [31:0]       mem_wdata,
  input  bus_pkg::strb_t    mem_strb,
  input  logic              retire_valid,
  input  isa_pkg::word_t    retire_pc,
  input  isa_pkg::reg_idx_t retire_rd,
  input  isa_pkg::word_t    retire_wd,
  input  logic              halted,
  input  logic [31:0]       image [512],
  output int                err_count,
  output int                retire_count,
  output int                model_count,
  output logic              model_halted
);
  import isa_pkg::*;

  word_t       regs [32];
  word_t       dmem [512];  // model copy of program and data
  word_t       pc;
  logic        seen_req;
  int          wr_count;    // write requests since the last retire
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;

  initial begin
    err_count    = 0;
    retire_count = 0;
    model_count  = 0;
    model_halted = 1'b0;
  end

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    err_count++;
  endtask

  task automatic watch_request();
    if (model_halted) begin
      $display("FAIL %0t: request to %h accepted after halt", $time, mem_addr);
      err_count++;
    end
    if (!seen_req) begin
      seen_req = 1'b1;
      if (mem_wen) report_mismatch("first request wen", mem_wen, 1'b0);
      if (mem_addr !== `RESET_PC) report_mismatch("first request addr", mem_addr, `RESET_PC);
    end
    if (mem_wen) begin
      wr_count++;
      wr_addr = mem_addr;
      wr_data = mem_wdata;
      wr_strb = mem_strb;
    end
  endtask

  // executes one instruction of the model and compares the retire
  task automatic check_retire();
    word_t      ins, a, b, v, npc, ea;
    logic [4:0] rd, exp_rd;
    logic [2:0] f3;
    logic       writes_rd, is_store;
    retire_count++;
    if (model_halted) begin
      $display("FAIL %0t: retire at pc %h after halt", $time, retire_pc);
      err_count++;
      return;
    end
    ins       = dmem[pc[10:2]];
    rd        = ins[11:7];
    f3        = ins[14:12];
    a         = regs[ins[19:15]];
    b         = regs[ins[24:20]];
    v         = '0;
    ea        = '0;
    npc       = pc + 32'd4;
    writes_rd = 1'b1;
    is_store  = 1'b0;
    case (ins[6:0])
      7'h33: begin
        case (f3)
          3'd0: v = ins[30] ? a - b : a + b;
          3'd1: v = a << b[4:0];
          3'd2: v = {31'b0, $signed(a) < $signed(b)};
          3'd3: v = {31'b0, a < b};
          3'd4: v = a ^ b;
          3'd5: if (ins[30]) v = $signed(a) >>> b[4:0]; else v = a >> b[4:0];
          3'd6: v = a | b;
          default: v = a & b;
        endcase
      end
      7'h13: begin
        ea = {{20{ins[31]}}, ins[31:20]};  // immediate operand
        case (f3)
          3'd0: v = a + ea;
          3'd4: v = a ^ ea;
          3'd6: v = a | ea;
          3'd7: v = a & ea;
          default: writes_rd = 1'b0;
        endcase
      end
      7'h37: v = {ins[31:12], 12'b0};
      7'h03: begin
        ea = a + {{20{ins[31]}}, ins[31:20]};
        v  = dmem[ea[10:2]];
      end
      7'h23: begin
        writes_rd = 1'b0;
        is_store  = 1'b1;
        ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        dmem[ea[10:2]] = b;
      end
      7'h63: begin
        writes_rd = 1'b0;
        if ((f3 == 3'd1) ? (a != b) : (a == b)) begin
          npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'h6f: begin
        v   = pc + 32'd4;
        npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: begin
        writes_rd = 1'b0;
        if (ins == 32'h0010_0073) model_halted = 1'b1;
      end
    endcase
    exp_rd = writes_rd ? rd : 5'd0;

    if (retire_pc !== pc) report_mismatch("retire_pc", retire_pc, pc);
    if (retire_rd !== exp_rd) report_mismatch("retire_rd", retire_rd, exp_rd);
    if (exp_rd != 0 && retire_wd !== v) report_mismatch("retire_wd", retire_wd, v);
    if (halted !== model_halted) report_mismatch("halted", halted, model_halted);
    if (wr_count != (is_store ? 1 : 0)) begin
      $display("FAIL %0t: %0d write requests for pc %h", $time, wr_count, pc);
      err_count++;
    end else if (is_store) begin
      if (wr_addr !== ea) report_mismatch("store addr", wr_addr, ea);
      if (wr_data !== b) report_mismatch("store data", wr_data, b);
      if (wr_strb !== 4'hf) report_mismatch("store strb", wr_strb, 4'hf);
    end
    wr_count = 0;
    if (exp_rd != 0) regs[exp_rd] = v;
    pc = npc;
    model_count++;
  endtask

  // sampled on the rising edge before the DUT flops update
  always @(posedge clk) begin
    if (!rst_n) begin
      if (retire_valid || halted || mem_req_valid) begin
        $display("FAIL %0t: retire_valid, halted or mem_req_valid high in reset", $time);
        err_count++;
      end
      for (int i = 0; i < 512; i++) dmem[i] = image[i];
      for (int i = 0; i < 32; i++) regs[i] = '0;
      pc           = `RESET_PC;
      seen_req     = 1'b0;
      wr_count     = 0;
      model_halted = 1'b0;
    end else begin
      // a fetch can be accepted in the same cycle as the previous retire
      if (retire_valid) check_retire();
      if (mem_req_valid && mem_req_ready) watch_request();
      if (model_halted && !halted) begin
        $display("FAIL %0t: halted dropped after the ebreak retired", $time);
        err_count++;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic              clk,
  input  logic              rst_n,
  output logic              mem_req_valid,
  input  logic              mem_req_ready,
  output bus_pkg::addr_t    mem_addr,
  output logic              mem_wen,
  output logic [31:0]       mem_wdata,
  output bus_pkg::strb_t    mem_strb,
  input  logic              mem_rsp_valid,
  input  logic [31:0]       mem_rdata,
  output logic              retire_valid,
  output isa_pkg::word_t    retire_pc,
  output isa_pkg::reg_idx_t retire_rd,
  output isa_pkg::word_t    retire_wd,
  output logic              halted
);
  import isa_pkg::*;

  mem_if fetch_bus ();
  mem_if data_bus ();

  logic     inst_valid, inst_ready, dec_valid, dec_ready, ex_valid, ex_ready;
  logic     mem_read, mem_write, is_ebreak, ex_mem_read, ex_mem_write, ex_is_ebreak;
  logic     wb_valid, wb_en, wb_halt;
  word_t    instruction, fetch_pc, rs1_data, rs2_data;
  word_t    op_a, op_b, store_data, imm, dec_pc;
  word_t    alu_result, ex_store_data, ex_pc, next_pc, wb_data, wb_pc;
  reg_idx_t rs1, rs2, rd, ex_rd, wb_rd;
  alu_op_t  alu_op;
  br_op_t   br_op;
  wb_sel_t  wb_sel, ex_wb_sel;

  // fetch pc travels under its own name, the stage ports all call it pc
  ifu ifu_i (.*, .fetch(fetch_bus), .pc(fetch_pc));
  idu idu_i (.*, .pc(fetch_pc));
  exu exu_i (.*);
  lsu lsu_i (.*, .data(data_bus));
  wbu wbu_i (.*);

  mem_arbiter mem_arbiter_i (.*, .fetch(fetch_bus), .data(data_bus));

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic           clk,
  input  logic           rst_n,
  mem_if.slave           fetch,
  mem_if.slave           data,
  output logic           mem_req_valid,
  input  logic           mem_req_ready,
  output bus_pkg::addr_t mem_addr,
  output logic           mem_wen,
  output logic [31:0]    mem_wdata,
  output bus_pkg::strb_t mem_strb,
  input  logic           mem_rsp_valid,
  input  logic [31:0]    mem_rdata
);

  logic busy;        // request accepted, response pending
  logic owner_data;
  logic pick_data;
  logic accept;

  assign pick_data = data.req_valid;  // data port wins ties

  assign mem_req_valid = !busy && (data.req_valid || fetch.req_valid);
  assign mem_addr      = pick_data ? data.addr  : fetch.addr;
  assign mem_wen       = pick_data ? data.wen   : fetch.wen;
  assign mem_wdata     = pick_data ? data.wdata : fetch.wdata;
  assign mem_strb      = pick_data ? data.strb  : fetch.strb;
  assign accept        = mem_req_valid && mem_req_ready;

  assign data.req_ready  = !busy && mem_req_ready && pick_data;
  assign fetch.req_ready = !busy && mem_req_ready && !pick_data;
  assign data.rsp_valid  = busy && owner_data && mem_rsp_valid;
  assign fetch.rsp_valid = busy && !owner_data && mem_rsp_valid;
  assign data.rdata      = mem_rdata;
  assign fetch.rdata     = mem_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      owner_data <= 1'b0;
    end else if (accept) begin
      busy       <= 1'b1;
      owner_data <= pick_data;
    end else if (mem_rsp_valid) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/wbu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module wbu (
  input  logic              clk,
  input  logic              rst_n,
  input  isa_pkg::reg_idx_t rs1,
  input  isa_pkg::reg_idx_t rs2,
  output isa_pkg::word_t    rs1_data,
  output isa_pkg::word_t    rs2_data,
  input  logic              wb_valid,
  input  isa_pkg::reg_idx_t wb_rd,
  input  isa_pkg::word_t    wb_data,
  input  logic              wb_en,
  input  isa_pkg::word_t    wb_pc,
  input  logic              wb_halt,
  output logic              retire_valid,
  output isa_pkg::word_t    retire_pc,
  output isa_pkg::reg_idx_t retire_rd,
  output isa_pkg::word_t    retire_wd,
  output logic              halted
);
  import isa_pkg::*;

  word_t regs [`NUM_REGS];
  logic  wr_en;

  assign wr_en = wb_valid && wb_en && (wb_rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      retire_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      if (wr_en) begin
        regs[wb_rd] <= wb_data;
      end
      retire_valid <= wb_valid;
      if (wb_valid && wb_halt) begin
        halted <= 1'b1;  // sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_valid) begin
      retire_pc <= wb_pc;
      retire_rd <= wr_en ? wb_rd : '0;
      retire_wd <= wr_en ? wb_data : '0;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- logic/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid,
  output logic              ex_ready,
  input  isa_pkg::word_t    alu_result,
  input  isa_pkg::word_t    ex_store_data,
  input  isa_pkg::word_t    ex_pc,
  input  isa_pkg::reg_idx_t ex_rd,
  input  isa_pkg::wb_sel_t  ex_wb_sel,
  input  logic              ex_mem_read,
  input  logic              ex_mem_write,
  input  logic              ex_is_ebreak,
  mem_if.master             data,
  output logic              wb_valid,
  output isa_pkg::reg_idx_t wb_rd,
  output isa_pkg::word_t    wb_data,
  output logic              wb_en,
  output isa_pkg::word_t    wb_pc,
  output logic              wb_halt
);
  import isa_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, WAIT, DONE} state_t;

  state_t state;
  logic   ex_fire;
  logic   wen_q;
  logic   mem_wb_q;  // loaded word replaces wb_data
  word_t  addr_q, wdata_q;

  assign ex_fire  = ex_valid && ex_ready;
  assign ex_ready = (state == IDLE);
  assign wb_valid = (state == DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (ex_fire) state <= (ex_mem_read || ex_mem_write) ? REQ : DONE;
        REQ:  if (data.req_valid && data.req_ready) state <= WAIT;
        WAIT: if (data.rsp_valid) state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ex_fire) begin
      addr_q   <= {alu_result[31:2], 2'b00};
      wdata_q  <= ex_store_data;
      wen_q    <= ex_mem_write;
      mem_wb_q <= (ex_wb_sel == WB_MEM);
      wb_rd    <= ex_rd;
      wb_en    <= (ex_rd != '0) && !ex_mem_write && !ex_is_ebreak;
      wb_pc    <= ex_pc;
      wb_halt  <= ex_is_ebreak;
      wb_data  <= (ex_wb_sel == WB_PC4) ? ex_pc + 32'd4 : alu_result;
    end else if (state == WAIT && data.rsp_valid && mem_wb_q) begin
      wb_data <= data.rdata;
    end
  end

  assign data.req_valid = (state == REQ);
  assign data.addr      = addr_q;
  assign data.wen       = wen_q;
  assign data.wdata     = wdata_q;
  assign data.strb      = 4'hf;  // word accesses only

endmodule

`default_nettype wire

//--- logic/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dec_valid,
  output logic              dec_ready,
  input  isa_pkg::word_t    op_a,
  input  isa_pkg::word_t    op_b,
  input  isa_pkg::word_t    store_data,
  input  isa_pkg::word_t    imm,
  input  isa_pkg::word_t    dec_pc,
  input  isa_pkg::alu_op_t  alu_op,
  input  isa_pkg::br_op_t   br_op,
  input  isa_pkg::wb_sel_t  wb_sel,
  input  logic              mem_read,
  input  logic              mem_write,
  input  isa_pkg::reg_idx_t rd,
  input  logic              is_ebreak,
  output logic              ex_valid,
  input  logic              ex_ready,
  output isa_pkg::word_t    alu_result,
  output isa_pkg::word_t    ex_store_data,
  output isa_pkg::word_t    ex_pc,
  output isa_pkg::reg_idx_t ex_rd,
  output isa_pkg::wb_sel_t  ex_wb_sel,
  output logic              ex_mem_read,
  output logic              ex_mem_write,
  output logic              ex_is_ebreak,
  output isa_pkg::word_t    next_pc
);
  import isa_pkg::*;

  word_t alu_y;
  logic  taken;

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_y = op_a - op_b;
      ALU_AND:    alu_y = op_a & op_b;
      ALU_OR:     alu_y = op_a | op_b;
      ALU_XOR:    alu_y = op_a ^ op_b;
      ALU_SLL:    alu_y = op_a << op_b[4:0];
      ALU_SRL:    alu_y = op_a >> op_b[4:0];
      ALU_SRA:    alu_y = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_y = {31'b0, op_a < op_b};
      ALU_PASS_B: alu_y = op_b;
      default:    alu_y = op_a + op_b;
    endcase
  end

  assign taken = (br_op == BR_JAL) ||
                 (br_op == BR_BEQ && op_a == op_b) ||
                 (br_op == BR_BNE && op_a != op_b);

  assign dec_ready = !ex_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (dec_valid && dec_ready) begin
      ex_valid <= 1'b1;
    end else if (ex_ready) begin
      ex_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      alu_result    <= alu_y;
      ex_store_data <= store_data;
      ex_pc         <= dec_pc;
      ex_rd         <= rd;
      ex_wb_sel     <= wb_sel;
      ex_mem_read   <= mem_read;
      ex_mem_write  <= mem_write;
      ex_is_ebreak  <= is_ebreak;
      next_pc       <= taken ? dec_pc + imm : dec_pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

//--- logic/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              inst_valid,
  output logic              inst_ready,
  input  isa_pkg::word_t    instruction,
  input  isa_pkg::word_t    pc,
  output isa_pkg::reg_idx_t rs1,
  output isa_pkg::reg_idx_t rs2,
  input  isa_pkg::word_t    rs1_data,
  input  isa_pkg::word_t    rs2_data,
  output logic              dec_valid,
  input  logic              dec_ready,
  output isa_pkg::word_t    op_a,
  output isa_pkg::word_t    op_b,
  output isa_pkg::word_t    store_data,
  output isa_pkg::word_t    imm,
  output isa_pkg::word_t    dec_pc,
  output isa_pkg::alu_op_t  alu_op,
  output isa_pkg::br_op_t   br_op,
  output isa_pkg::wb_sel_t  wb_sel,
  output logic              mem_read,
  output logic              mem_write,
  output isa_pkg::reg_idx_t rd,
  output logic              is_ebreak
);
  import isa_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam word_t      EBREAK     = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j, imm_d;
  logic       use_imm, load_d, store_d, ebreak_d;
  alu_op_t    alu_d;
  br_op_t     br_d;
  wb_sel_t    wb_d;
  reg_idx_t   rd_d;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign rs1    = instruction[19:15];
  assign rs2    = instruction[24:20];

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
  assign imm_u = {instruction[31:12], 12'b0};
  assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  // anything unknown falls through as addi x0
  always_comb begin
    alu_d    = ALU_ADD;
    br_d     = BR_NONE;
    wb_d     = WB_ALU;
    imm_d    = imm_i;
    use_imm  = 1'b1;
    load_d   = 1'b0;
    store_d  = 1'b0;
    ebreak_d = 1'b0;
    rd_d     = instruction[11:7];
    case (opcode)
      OPC_OP: begin
        use_imm = 1'b0;
        case (funct3)
          3'b000: alu_d = instruction[30] ? ALU_SUB : ALU_ADD;
          3'b001: alu_d = ALU_SLL;
          3'b010: alu_d = ALU_SLT;
          3'b011: alu_d = ALU_SLTU;
          3'b100: alu_d = ALU_XOR;
          3'b101: alu_d = instruction[30] ? ALU_SRA : ALU_SRL;
          3'b110: alu_d = ALU_OR;
          default: alu_d = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: alu_d = ALU_ADD;
          3'b100: alu_d = ALU_XOR;
          3'b110: alu_d = ALU_OR;
          3'b111: alu_d = ALU_AND;
          default: rd_d = '0;
        endcase
      end
      OPC_LUI: begin
        alu_d = ALU_PASS_B;
        imm_d = imm_u;
      end
      OPC_LOAD: begin
        wb_d   = WB_MEM;
        load_d = 1'b1;
      end
      OPC_STORE: begin
        imm_d   = imm_s;
        store_d = 1'b1;
        rd_d    = '0;
      end
      OPC_BRANCH: begin
        br_d    = (funct3 == 3'b001) ? BR_BNE : BR_BEQ;
        imm_d   = imm_b;
        use_imm = 1'b0;  // compare rs1 against rs2
        rd_d    = '0;
      end
      OPC_JAL: begin
        br_d  = BR_JAL;
        wb_d  = WB_PC4;
        imm_d = imm_j;
      end
      default: begin
        ebreak_d = (instruction == EBREAK);
        rd_d     = '0;
      end
    endcase
  end

  assign inst_ready = !dec_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (inst_valid && inst_ready) begin
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid && inst_ready) begin
      op_a       <= rs1_data;
      op_b       <= use_imm ? imm_d : rs2_data;
      store_data <= rs2_data;
      imm        <= imm_d;
      dec_pc     <= pc;
      alu_op     <= alu_d;
      br_op      <= br_d;
      wb_sel     <= wb_d;
      mem_read   <= load_d;
      mem_write  <= store_d;
      rd         <= rd_d;
      is_ebreak  <= ebreak_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/ifu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module ifu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             halted,
  input  logic             wb_valid,
  input  logic [`XLEN-1:0] next_pc,
  mem_if.master            fetch,
  output logic             inst_valid,
  input  logic             inst_ready,
  output logic [`XLEN-1:0] instruction,
  output logic [`XLEN-1:0] pc
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT, HOLD} state_t;

  state_t state;
  logic   boot;  // first fetch after reset

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      boot  <= 1'b1;
      pc    <= `RESET_PC;
    end else begin
      if (wb_valid) begin
        pc <= next_pc;
      end
      case (state)
        IDLE: begin
          if (boot || wb_valid) begin
            state <= REQ;
            boot  <= 1'b0;
          end
        end
        REQ: begin
          if (halted) begin
            state <= IDLE;  // ebreak retired, stay parked
          end else if (fetch.req_valid && fetch.req_ready) begin
            state <= WAIT;
          end
        end
        WAIT: if (fetch.rsp_valid) state <= HOLD;
        HOLD: if (inst_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WAIT && fetch.rsp_valid) begin
      instruction <= fetch.rdata;
    end
  end

  assign fetch.req_valid = (state == REQ) && !halted;
  assign fetch.addr      = pc;
  assign fetch.wen       = 1'b0;
  assign fetch.wdata     = '0;
  assign fetch.strb      = 4'hf;
  assign inst_valid      = (state == HOLD);

endmodule

`default_nettype wire

//--- logic/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
  import bus_pkg::*;

  logic        req_valid;
  logic        req_ready;
  addr_t       addr;
  logic        wen;
  logic [31:0] wdata;
  strb_t       strb;
  logic        rsp_valid;  // one pulse per accepted request
  logic [31:0] rdata;

  modport master (output req_valid, addr, wen, wdata, strb,
                  input  req_ready, rsp_valid, rdata);
  modport slave  (input  req_valid, addr, wen, wdata, strb,
                  output req_ready, rsp_valid, rdata);
endinterface

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [3:0]  strb_t;

endpackage

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none
`include "core_consts.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B  // lui
  } alu_op_t;

  typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} br_op_t;

  // write-back source
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

endpackage

`default_nettype wire

//--- logic/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`define XLEN     32
`define NUM_REGS 32  // x0 included

`endif
